//--- tb.f
hw/ctrl_mon_pkg.sv
hw/obs_capture.sv
hw/seq_rule_check.sv
hw/comb_rule_check.sv
hw/violation_log.sv
hw/ctrl_mon_top.sv
sim/tb_ctrl_mon.sv

//--- Makefile
# Verilator build and run for the controller monitor testbench

VERILATOR ?= verilator
FILELIST  ?= tb.f
TOP       ?= tb_ctrl_mon
RTL_TOP   ?= ctrl_mon_top
BUILD_DIR ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# The simulation output is searched for the pass line, any miss fails make
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- sim/tb_ctrl_mon.sv
/*
 * Testbench for the controller run-time monitor.
 * Applies a table of observation pairs, each framed by a clear pulse and
 * idle cycles, and checks the sticky flags, count and first rule.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_ctrl_mon;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 8;
  localparam int CNT_W      = 8;
  // Clear, two samples, four idle samples and the check
  localparam int ROW_CYCLES = 8;
  localparam int IDLE_CYCLES = 4;

  // The expected first rule of a table entry only matters with violations
  typedef struct packed {
    ctrl_mon_pkg::obs_t      prev_obs;
    ctrl_mon_pkg::obs_t      cur_obs;
    ctrl_mon_pkg::viol_vec_t exp_viol;
    ctrl_mon_pkg::rule_e     exp_first;
  } row_t;

  logic                    clk;
  logic                    rst_n_i;
  ctrl_mon_pkg::obs_t      obs_i;
  logic                    clear_i;
  ctrl_mon_pkg::viol_vec_t viol_flags_o;
  logic [CNT_W-1:0]        viol_count_o;
  ctrl_mon_pkg::rule_e     first_rule_o;
  logic                    first_valid_o;

  row_t rows[$];
  logic table_ready;
  int   n_checks;
  int   n_errors;

  ctrl_mon_top #(
    .CNT_W (CNT_W)
  ) dut0 (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .obs_i         (obs_i),
    .clear_i       (clear_i),
    .viol_flags_o  (viol_flags_o),
    .viol_count_o  (viol_count_o),
    .first_rule_o  (first_rule_o),
    .first_valid_o (first_valid_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Sample builders
  ////////////////////////////////////////////////////////////////////////////

  // Quiet machine-mode cycle with nothing in writeback
  function automatic ctrl_mon_pkg::obs_t idle_obs();
    ctrl_mon_pkg::obs_t o;
    o          = '0;
    o.priv_lvl = ctrl_mon_pkg::PRIV_LVL_M;
    return o;
  endfunction

  function automatic ctrl_mon_pkg::obs_t pc_obs(input ctrl_mon_pkg::pc_mux_e mux);
    ctrl_mon_pkg::obs_t o;
    o        = idle_obs();
    o.pc_set = 1'b1;
    o.pc_mux = mux;
    return o;
  endfunction

  function automatic ctrl_mon_pkg::obs_t fencei_obs(input logic in_wb, input logic ready,
                                                    input logic req, input logic ack);
    ctrl_mon_pkg::obs_t o;
    o                  = idle_obs();
    o.fencei_in_wb     = in_wb;
    o.fencei_ready     = ready;
    o.fencei_flush_req = req;
    o.fencei_flush_ack = ack;
    return o;
  endfunction

  // Writeback word as a core would present it when trapped as illegal or decoded
  function automatic ctrl_mon_pkg::obs_t wb_obs(
    input logic [31:0]             word,
    input ctrl_mon_pkg::priv_lvl_e priv,
    input logic                    tw,
    input logic                    illegal,
    input logic                    prior_exc
  );
    ctrl_mon_pkg::obs_t o;
    o                 = idle_obs();
    o.wb_instr_valid  = 1'b1;
    o.wb_instr_word   = word;
    o.priv_lvl        = priv;
    o.mstatus_tw      = tw;
    o.wb_prior_exc    = prior_exc;
    o.exception_in_wb = illegal;
    o.exception_cause = illegal ? ctrl_mon_pkg::EXC_CAUSE_ILLEGAL_INSN : 8'h00;
    // A trapped instruction is not decoded as itself
    o.wb_mret_insn    = !illegal && (word == ctrl_mon_pkg::MRET_WORD);
    o.wb_wfi_insn     = !illegal && (word == ctrl_mon_pkg::WFI_WORD);
    return o;
  endfunction

  function automatic ctrl_mon_pkg::viol_vec_t rule_bit(input ctrl_mon_pkg::rule_e r);
    return ctrl_mon_pkg::viol_vec_t'(1) << r;
  endfunction

  function automatic int count_bits(input ctrl_mon_pkg::viol_vec_t v);
    int n;
    n = 0;
    for (int i = 0; i < ctrl_mon_pkg::NUM_RULES; i++) begin
      if (v[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic add_row(input ctrl_mon_pkg::obs_t prev_obs, input ctrl_mon_pkg::obs_t cur_obs,
                         input ctrl_mon_pkg::viol_vec_t exp_viol,
                         input ctrl_mon_pkg::rule_e exp_first);
    row_t row;
    row.prev_obs  = prev_obs;
    row.cur_obs   = cur_obs;
    row.exp_viol  = exp_viol;
    row.exp_first = exp_first;
    rows.push_back(row);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    ctrl_mon_pkg::obs_t p;
    ctrl_mon_pkg::obs_t c;
    // Back-to-back PC updates where an mret counts as a jump
    add_row(pc_obs(ctrl_mon_pkg::PC_BRANCH), pc_obs(ctrl_mon_pkg::PC_BRANCH),
            rule_bit(ctrl_mon_pkg::RULE_BRANCH_B2B), ctrl_mon_pkg::RULE_BRANCH_B2B);
    add_row(pc_obs(ctrl_mon_pkg::PC_JUMP), pc_obs(ctrl_mon_pkg::PC_MRET),
            rule_bit(ctrl_mon_pkg::RULE_JUMP_B2B), ctrl_mon_pkg::RULE_JUMP_B2B);
    add_row(pc_obs(ctrl_mon_pkg::PC_BRANCH), pc_obs(ctrl_mon_pkg::PC_JUMP),
            '0, ctrl_mon_pkg::RULE_BRANCH_B2B);

    // Writes under a killed writeback
    c          = idle_obs();
    c.kill_wb  = 1'b1;
    c.rf_we_wb = 1'b1;
    add_row(idle_obs(), c, rule_bit(ctrl_mon_pkg::RULE_KILL_WB_WRITE),
            ctrl_mon_pkg::RULE_KILL_WB_WRITE);
    c          = idle_obs();
    c.kill_wb  = 1'b1;
    c.csr_we   = 1'b1;
    add_row(idle_obs(), c, rule_bit(ctrl_mon_pkg::RULE_KILL_WB_WRITE),
            ctrl_mon_pkg::RULE_KILL_WB_WRITE);
    c          = idle_obs();
    c.rf_we_wb = 1'b1;
    c.csr_we   = 1'b1;
    add_row(idle_obs(), c, '0, ctrl_mon_pkg::RULE_BRANCH_B2B);

    // A fence.i request in the second sample carries its acknowledge so the
    // drop into the idle cycle that follows is legal
    add_row(idle_obs(), fencei_obs(1'b0, 1'b1, 1'b1, 1'b1),
            rule_bit(ctrl_mon_pkg::RULE_FENCEI_REQ_NO_INSN),
            ctrl_mon_pkg::RULE_FENCEI_REQ_NO_INSN);
    add_row(idle_obs(), fencei_obs(1'b1, 1'b0, 1'b1, 1'b1),
            rule_bit(ctrl_mon_pkg::RULE_FENCEI_REQ_NOT_READY),
            ctrl_mon_pkg::RULE_FENCEI_REQ_NOT_READY);
    add_row(fencei_obs(1'b1, 1'b1, 1'b1, 1'b0), idle_obs(),
            rule_bit(ctrl_mon_pkg::RULE_FENCEI_EARLY_CLEAR),
            ctrl_mon_pkg::RULE_FENCEI_EARLY_CLEAR);
    add_row(fencei_obs(1'b1, 1'b1, 1'b1, 1'b1), fencei_obs(1'b1, 1'b1, 1'b1, 1'b1),
            rule_bit(ctrl_mon_pkg::RULE_FENCEI_REQ_HELD),
            ctrl_mon_pkg::RULE_FENCEI_REQ_HELD);
    add_row(fencei_obs(1'b1, 1'b1, 1'b1, 1'b0), fencei_obs(1'b1, 1'b1, 1'b1, 1'b1),
            '0, ctrl_mon_pkg::RULE_BRANCH_B2B);

    // Privilege decode of mret and wfi
    add_row(idle_obs(),
            wb_obs(ctrl_mon_pkg::MRET_WORD, ctrl_mon_pkg::PRIV_LVL_U, 1'b0, 1'b0, 1'b0),
            rule_bit(ctrl_mon_pkg::RULE_MRET_PRIV), ctrl_mon_pkg::RULE_MRET_PRIV);
    add_row(idle_obs(),
            wb_obs(ctrl_mon_pkg::MRET_WORD, ctrl_mon_pkg::PRIV_LVL_M, 1'b0, 1'b0, 1'b0),
            '0, ctrl_mon_pkg::RULE_BRANCH_B2B);
    add_row(idle_obs(),
            wb_obs(ctrl_mon_pkg::MRET_WORD, ctrl_mon_pkg::PRIV_LVL_U, 1'b0, 1'b1, 1'b0),
            '0, ctrl_mon_pkg::RULE_BRANCH_B2B);
    add_row(idle_obs(),
            wb_obs(ctrl_mon_pkg::WFI_WORD, ctrl_mon_pkg::PRIV_LVL_U, 1'b1, 1'b0, 1'b0),
            rule_bit(ctrl_mon_pkg::RULE_WFI_TW), ctrl_mon_pkg::RULE_WFI_TW);
    add_row(idle_obs(),
            wb_obs(ctrl_mon_pkg::WFI_WORD, ctrl_mon_pkg::PRIV_LVL_U, 1'b0, 1'b0, 1'b0),
            '0, ctrl_mon_pkg::RULE_BRANCH_B2B);
    // An earlier fault on the writeback instruction hides both rules
    add_row(idle_obs(),
            wb_obs(ctrl_mon_pkg::MRET_WORD, ctrl_mon_pkg::PRIV_LVL_U, 1'b0, 1'b0, 1'b1),
            '0, ctrl_mon_pkg::RULE_BRANCH_B2B);
    add_row(idle_obs(),
            wb_obs(ctrl_mon_pkg::WFI_WORD, ctrl_mon_pkg::PRIV_LVL_U, 1'b1, 1'b0, 1'b1),
            '0, ctrl_mon_pkg::RULE_BRANCH_B2B);

    // Several rules in the same cycle
    c          = wb_obs(ctrl_mon_pkg::MRET_WORD, ctrl_mon_pkg::PRIV_LVL_U, 1'b0, 1'b0, 1'b0);
    c.pc_set   = 1'b1;
    c.pc_mux   = ctrl_mon_pkg::PC_BRANCH;
    c.kill_wb  = 1'b1;
    c.rf_we_wb = 1'b1;
    add_row(pc_obs(ctrl_mon_pkg::PC_BRANCH), c,
            rule_bit(ctrl_mon_pkg::RULE_BRANCH_B2B) |
            rule_bit(ctrl_mon_pkg::RULE_KILL_WB_WRITE) |
            rule_bit(ctrl_mon_pkg::RULE_MRET_PRIV), ctrl_mon_pkg::RULE_BRANCH_B2B);

    // Violations spread over both samples with the kill one cycle ahead
    p                  = idle_obs();
    p.kill_wb          = 1'b1;
    p.csr_we           = 1'b1;
    c                  = wb_obs(ctrl_mon_pkg::WFI_WORD, ctrl_mon_pkg::PRIV_LVL_U,
                                1'b1, 1'b0, 1'b0);
    c.fencei_flush_req = 1'b1;
    c.fencei_flush_ack = 1'b1;
    add_row(p, c,
            rule_bit(ctrl_mon_pkg::RULE_KILL_WB_WRITE) |
            rule_bit(ctrl_mon_pkg::RULE_FENCEI_REQ_NO_INSN) |
            rule_bit(ctrl_mon_pkg::RULE_FENCEI_REQ_NOT_READY) |
            rule_bit(ctrl_mon_pkg::RULE_WFI_TW), ctrl_mon_pkg::RULE_KILL_WB_WRITE);

    // Clean row right after the busy ones
    add_row(idle_obs(), idle_obs(), '0, ctrl_mon_pkg::RULE_BRANCH_B2B);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Driving and checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_sample(input ctrl_mon_pkg::obs_t o, input logic clr);
    @(negedge clk);
    obs_i   = o;
    clear_i = clr;
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic run_row(input int r);
    row_t row;
    row = rows[r];
    apply_sample(idle_obs(), 1'b1);
    apply_sample(row.prev_obs, 1'b0);
    apply_sample(row.cur_obs, 1'b0);
    // Long enough for the second sample and its drop into idle to be logged
    repeat (IDLE_CYCLES) apply_sample(idle_obs(), 1'b0);
    @(negedge clk);
    check_value(32'(viol_flags_o), 32'(row.exp_viol), $sformatf("row %0d flags", r));
    check_value(32'(viol_count_o), 32'(count_bits(row.exp_viol)),
                $sformatf("row %0d count", r));
    check_value(32'(first_valid_o), 32'(|row.exp_viol), $sformatf("row %0d first_valid", r));
    if (|row.exp_viol) begin
      check_value(32'(first_rule_o), 32'(row.exp_first), $sformatf("row %0d first_rule", r));
    end
  endtask

  // Watchdog sized from the table once it exists
  initial begin
    int limit_ns;
    wait (table_ready === 1'b1);
    limit_ns = (rows.size() * ROW_CYCLES + RST_CYCLES + 4) * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout: the table did not finish within %0d ns", limit_ns);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    clear_i     = 1'b0;
    obs_i       = idle_obs();
    n_checks    = 0;
    n_errors    = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n_i = 1'b1;
    for (int r = 0; r < rows.size(); r++) begin
      run_row(r);
    end
    $display("Rows: %0d, checks: %0d, errors: %0d", rows.size(), n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/ctrl_mon_top.sv
/*
 * Controller run-time monitor, top level.
 * Capture, rule check and log stages in a fixed three-cycle pipeline
 * that takes one observation every cycle and never stalls.
 */
`timescale 1ns/100ps
`default_nettype none

module ctrl_mon_top #(
  parameter int CNT_W = 8
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  ctrl_mon_pkg::obs_t      obs_i,
  input  logic                    clear_i,
  output ctrl_mon_pkg::viol_vec_t viol_flags_o,
  output logic [CNT_W-1:0]        viol_count_o,
  output ctrl_mon_pkg::rule_e     first_rule_o,
  output logic                    first_valid_o
);

  ctrl_mon_pkg::obs_t      cur_obs;
  ctrl_mon_pkg::obs_t      prev_obs;
  logic                    prev_valid;
  ctrl_mon_pkg::viol_vec_t seq_viol;
  ctrl_mon_pkg::viol_vec_t comb_viol;
  ctrl_mon_pkg::viol_vec_t rule_viol;

  // Stage 1, sample and history
  obs_capture u_obs_capture (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .obs_i        (obs_i),
    .cur_obs_o    (cur_obs),
    .prev_obs_o   (prev_obs),
    .prev_valid_o (prev_valid)
  );

  // Stage 2, both checkers work on the same captured sample in parallel
  seq_rule_check u_seq_rule_check (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .cur_obs_i    (cur_obs),
    .prev_obs_i   (prev_obs),
    .prev_valid_i (prev_valid),
    .seq_viol_o   (seq_viol)
  );

  comb_rule_check u_comb_rule_check (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cur_obs_i   (cur_obs),
    .comb_viol_o (comb_viol)
  );

  // Each checker owns a disjoint set of rule bits
  assign rule_viol = seq_viol | comb_viol;

  // Stage 3, sticky results
  violation_log #(
    .CNT_W (CNT_W)
  ) u_violation_log (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .clear_i       (clear_i),
    .rule_viol_i   (rule_viol),
    .viol_flags_o  (viol_flags_o),
    .viol_count_o  (viol_count_o),
    .first_rule_o  (first_rule_o),
    .first_valid_o (first_valid_o)
  );

endmodule

`default_nettype wire

//--- hw/violation_log.sv
/*
 * Violation log.
 * Collects sticky per-rule flags, a saturating violation count and the
 * first rule that failed since reset or the last clear.
 */
`timescale 1ns/100ps
`default_nettype none

module violation_log #(
  parameter int CNT_W = 8
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    clear_i,
  input  ctrl_mon_pkg::viol_vec_t rule_viol_i,
  output ctrl_mon_pkg::viol_vec_t viol_flags_o,
  output logic [CNT_W-1:0]        viol_count_o,
  output ctrl_mon_pkg::rule_e     first_rule_o,
  output logic                    first_valid_o
);

  // Enough bits to hold the number of rules that fire in one cycle
  localparam int POP_W = $clog2(ctrl_mon_pkg::NUM_RULES + 1);
  // Sum width with room for the carry above the count
  localparam int SUM_W = CNT_W + POP_W;
  localparam logic [SUM_W-1:0] SAT_LIMIT = {{POP_W{1'b0}}, {CNT_W{1'b1}}};

  ctrl_mon_pkg::viol_vec_t flags_q;
  ctrl_mon_pkg::viol_vec_t flags_d;
  logic [CNT_W-1:0]        count_q;
  logic [CNT_W-1:0]        count_d;
  logic [CNT_W-1:0]        count_base;
  logic [POP_W-1:0]        pop;
  logic [SUM_W-1:0]        sum;
  ctrl_mon_pkg::rule_e     first_rule_q;
  ctrl_mon_pkg::rule_e     first_rule_d;
  logic                    first_valid_q;
  logic                    first_valid_d;

  // Number of rules violated in this cycle
  always_comb begin
    pop = '0;
    for (int i = 0; i < ctrl_mon_pkg::NUM_RULES; i++) begin
      pop = pop + POP_W'(rule_viol_i[i]);
    end
  end

  // A clear drops the old state, new violations still land on top of it
  assign count_base = clear_i ? '0 : count_q;
  assign sum        = SUM_W'(count_base) + SUM_W'(pop);
  assign count_d    = (sum > SAT_LIMIT) ? {CNT_W{1'b1}} : sum[CNT_W-1:0];

  assign flags_d = (clear_i ? '0 : flags_q) | rule_viol_i;

  always_comb begin
    first_valid_d = clear_i ? 1'b0 : first_valid_q;
    first_rule_d  = clear_i ? ctrl_mon_pkg::rule_e'(0) : first_rule_q;
    if (!first_valid_d && (|rule_viol_i)) begin
      first_valid_d = 1'b1;
      // Walk downwards so the lowest set index is the one that sticks
      for (int i = ctrl_mon_pkg::NUM_RULES - 1; i >= 0; i--) begin
        if (rule_viol_i[i]) begin
          first_rule_d = ctrl_mon_pkg::rule_e'(i);
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      flags_q       <= '0;
      count_q       <= '0;
      first_rule_q  <= ctrl_mon_pkg::rule_e'(0);
      first_valid_q <= 1'b0;
    end else begin
      flags_q       <= flags_d;
      count_q       <= count_d;
      first_rule_q  <= first_rule_d;
      first_valid_q <= first_valid_d;
    end
  end

  assign viol_flags_o  = flags_q;
  assign viol_count_o  = count_q;
  assign first_rule_o  = first_rule_q;
  assign first_valid_o = first_valid_q;

endmodule

`default_nettype wire

//--- hw/comb_rule_check.sv
/*
 * Single-sample rule checker.
 * Checks writeback kill against the write enables, the fence.i request
 * conditions, and the privilege outcome of mret and wfi in writeback.
 */
`timescale 1ns/100ps
`default_nettype none

module comb_rule_check (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  ctrl_mon_pkg::obs_t      cur_obs_i,
  output ctrl_mon_pkg::viol_vec_t comb_viol_o
);

  logic                    priv_chk;
  logic                    is_mret;
  logic                    is_wfi;
  logic                    user_mode;
  logic                    mach_mode;
  logic                    illegal_seen;
  logic                    mret_u_bad;
  logic                    mret_m_bad;
  logic                    wfi_tw_bad;
  logic                    wfi_ntw_bad;
  ctrl_mon_pkg::viol_vec_t viol_d;
  ctrl_mon_pkg::viol_vec_t viol_q;

  ////////////////////////////////////////////////////////////////////////////
  // Privilege decode of the writeback word
  ////////////////////////////////////////////////////////////////////////////

  // MPU, bus and trigger events outrank the privilege check
  assign priv_chk = cur_obs_i.wb_instr_valid && !cur_obs_i.wb_prior_exc;

  assign is_mret = priv_chk && (cur_obs_i.wb_instr_word == ctrl_mon_pkg::MRET_WORD);
  assign is_wfi  = priv_chk && (cur_obs_i.wb_instr_word == ctrl_mon_pkg::WFI_WORD);

  assign user_mode = (cur_obs_i.priv_lvl == ctrl_mon_pkg::PRIV_LVL_U);
  assign mach_mode = (cur_obs_i.priv_lvl == ctrl_mon_pkg::PRIV_LVL_M);

  // Writeback raised an illegal instruction exception this cycle
  assign illegal_seen = cur_obs_i.exception_in_wb &&
                        (cur_obs_i.exception_cause == ctrl_mon_pkg::EXC_CAUSE_ILLEGAL_INSN);

  // mret from user mode must trap as illegal and must not be decoded as mret
  assign mret_u_bad = is_mret && user_mode &&
                      !(illegal_seen && !cur_obs_i.wb_mret_insn);

  // mret from machine mode must execute cleanly
  assign mret_m_bad = is_mret && mach_mode &&
                      !(!cur_obs_i.exception_in_wb && cur_obs_i.wb_mret_insn);

  // With mstatus.TW set, wfi from user mode is illegal
  assign wfi_tw_bad = is_wfi && user_mode && cur_obs_i.mstatus_tw &&
                      !(illegal_seen && !cur_obs_i.wb_wfi_insn);

  // With TW clear it is a plain wfi, unless debug keeps the core awake
  assign wfi_ntw_bad = is_wfi && user_mode && !cur_obs_i.mstatus_tw &&
                       !cur_obs_i.debug_wfi_no_sleep &&
                       !(!cur_obs_i.exception_in_wb && cur_obs_i.wb_wfi_insn);

  ////////////////////////////////////////////////////////////////////////////
  // Rule vector
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    viol_d = '0;
    // A killed writeback must not update the register file or any CSR
    viol_d[ctrl_mon_pkg::RULE_KILL_WB_WRITE] =
      cur_obs_i.kill_wb && (cur_obs_i.rf_we_wb || cur_obs_i.csr_we);
    // The flush request is only legal with a fence.i in writeback
    viol_d[ctrl_mon_pkg::RULE_FENCEI_REQ_NO_INSN] =
      cur_obs_i.fencei_flush_req && !cur_obs_i.fencei_in_wb;
    // and with the write buffer drained
    viol_d[ctrl_mon_pkg::RULE_FENCEI_REQ_NOT_READY] =
      cur_obs_i.fencei_flush_req && !cur_obs_i.fencei_ready;
    viol_d[ctrl_mon_pkg::RULE_MRET_PRIV] = mret_u_bad || mret_m_bad;
    viol_d[ctrl_mon_pkg::RULE_WFI_TW]    = wfi_tw_bad || wfi_ntw_bad;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      viol_q <= '0;
    end else begin
      viol_q <= viol_d;
    end
  end

  assign comb_viol_o = viol_q;

endmodule

`default_nettype wire

//--- hw/seq_rule_check.sv
/*
 * Two-sample rule checker.
 * Compares the previous and current observation for back-to-back PC
 * updates and for the fence.i request release, one registered bit per rule.
 */
`timescale 1ns/100ps
`default_nettype none

module seq_rule_check (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  ctrl_mon_pkg::obs_t      cur_obs_i,
  input  ctrl_mon_pkg::obs_t      prev_obs_i,
  input  logic                    prev_valid_i,
  output ctrl_mon_pkg::viol_vec_t seq_viol_o
);

  logic                    branch_cur;
  logic                    branch_prev;
  logic                    jump_cur;
  logic                    jump_prev;
  logic                    req_fell;
  logic                    req_ack_prev;
  ctrl_mon_pkg::viol_vec_t viol_d;
  ctrl_mon_pkg::viol_vec_t viol_q;

  ////////////////////////////////////////////////////////////////////////////
  // PC update decode
  ////////////////////////////////////////////////////////////////////////////

  // IF and ID are killed after a taken branch, so two in a row is a bug
  assign branch_cur  = cur_obs_i.pc_set && (cur_obs_i.pc_mux == ctrl_mon_pkg::PC_BRANCH);
  assign branch_prev = prev_obs_i.pc_set && (prev_obs_i.pc_mux == ctrl_mon_pkg::PC_BRANCH);

  // An mret redirects from ID like a jump and is treated as one
  assign jump_cur  = cur_obs_i.pc_set &&
                     ((cur_obs_i.pc_mux == ctrl_mon_pkg::PC_JUMP) ||
                      (cur_obs_i.pc_mux == ctrl_mon_pkg::PC_MRET));
  assign jump_prev = prev_obs_i.pc_set &&
                     ((prev_obs_i.pc_mux == ctrl_mon_pkg::PC_JUMP) ||
                      (prev_obs_i.pc_mux == ctrl_mon_pkg::PC_MRET));

  ////////////////////////////////////////////////////////////////////////////
  // fence.i request release
  ////////////////////////////////////////////////////////////////////////////

  // Falling edge of the flush request seen across the two samples
  assign req_fell     = prev_obs_i.fencei_flush_req && !cur_obs_i.fencei_flush_req;
  assign req_ack_prev = prev_obs_i.fencei_flush_req && prev_obs_i.fencei_flush_ack;

  always_comb begin
    viol_d = '0;
    // Nothing here is meaningful until the history holds a real sample
    if (prev_valid_i) begin
      viol_d[ctrl_mon_pkg::RULE_BRANCH_B2B] = branch_prev && branch_cur;
      viol_d[ctrl_mon_pkg::RULE_JUMP_B2B]   = jump_prev && jump_cur;
      // The request may only drop after it was acknowledged
      viol_d[ctrl_mon_pkg::RULE_FENCEI_EARLY_CLEAR] =
        req_fell && !prev_obs_i.fencei_flush_ack;
      // After request with acknowledge the request must drop at once
      viol_d[ctrl_mon_pkg::RULE_FENCEI_REQ_HELD] =
        req_ack_prev && cur_obs_i.fencei_flush_req;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      viol_q <= '0;
    end else begin
      viol_q <= viol_d;
    end
  end

  assign seq_viol_o = viol_q;

endmodule

`default_nettype wire

//--- hw/obs_capture.sv
/*
 * Observation capture stage.
 * Registers the controller observation every cycle and keeps the sample
 * before it, flagged valid once two samples exist since reset.
 */
`timescale 1ns/100ps
`default_nettype none

module obs_capture (
  input  logic               clk,
  input  logic               rst_n_i,
  input  ctrl_mon_pkg::obs_t obs_i,
  output ctrl_mon_pkg::obs_t cur_obs_o,
  output ctrl_mon_pkg::obs_t prev_obs_o,
  output logic               prev_valid_o
);

  ctrl_mon_pkg::obs_t cur_obs_q;
  ctrl_mon_pkg::obs_t prev_obs_q;
  logic               cur_valid_q;
  logic               prev_valid_q;

  // The current sample feeds the single-sample rules with no valid of its
  // own, so it comes out of reset as an all-zero sample that breaks no rule
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cur_obs_q <= '0;
    end else begin
      cur_obs_q <= obs_i;
    end
  end

  // History register, only read while prev_valid is high
  always_ff @(posedge clk) begin
    prev_obs_q <= cur_obs_q;
  end

  // First edge fills the current sample, second edge fills the history
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cur_valid_q  <= 1'b0;
      prev_valid_q <= 1'b0;
    end else begin
      cur_valid_q  <= 1'b1;
      prev_valid_q <= cur_valid_q;
    end
  end

  assign cur_obs_o    = cur_obs_q;
  assign prev_obs_o   = prev_obs_q;
  assign prev_valid_o = prev_valid_q;

endmodule

`default_nettype wire

//--- hw/ctrl_mon_pkg.sv
/*
 * Controller run-time monitor definitions.
 * Holds the per-cycle observation of the controller and writeback stage,
 * the PC source and privilege encodings, the rule indices and the
 * instruction words that the rule checkers decode.
 */
`default_nettype none

package ctrl_mon_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Controller encodings
  ////////////////////////////////////////////////////////////////////////////

  // PC source selected by the controller when pc_set is high
  typedef enum logic [2:0] {
    PC_OTHER  = 3'd0,
    PC_BRANCH = 3'd1,
    PC_JUMP   = 3'd2,
    PC_MRET   = 3'd3,
    PC_DRET   = 3'd4
  } pc_mux_e;

  // Only user and machine mode exist on the observed core
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Fixed instruction words decoded in writeback
  localparam logic [31:0] MRET_WORD = 32'h3020_0073;
  localparam logic [31:0] WFI_WORD  = 32'h1050_0073;

  // mcause code for an illegal instruction exception
  localparam logic [7:0] EXC_CAUSE_ILLEGAL_INSN = 8'h02;

  ////////////////////////////////////////////////////////////////////////////
  // Rules and violation vectors
  ////////////////////////////////////////////////////////////////////////////

  // The order sets the priority of the first-rule report, lowest wins
  typedef enum logic [3:0] {
    RULE_BRANCH_B2B           = 4'd0,
    RULE_JUMP_B2B             = 4'd1,
    RULE_KILL_WB_WRITE        = 4'd2,
    RULE_FENCEI_REQ_NO_INSN   = 4'd3,
    RULE_FENCEI_REQ_NOT_READY = 4'd4,
    RULE_FENCEI_EARLY_CLEAR   = 4'd5,
    RULE_FENCEI_REQ_HELD      = 4'd6,
    RULE_MRET_PRIV            = 4'd7,
    RULE_WFI_TW               = 4'd8
  } rule_e;

  localparam int NUM_RULES = 9;

  // One bit per rule, bit position equals the rule_e value
  typedef logic [NUM_RULES-1:0] viol_vec_t;

  ////////////////////////////////////////////////////////////////////////////
  // Observation sample
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    // PC update from the controller FSM
    logic        pc_set;
    pc_mux_e     pc_mux;
    // Writeback kill and the write enables it must suppress
    logic        kill_wb;
    logic        rf_we_wb;
    logic        csr_we;
    // fence.i flush handshake towards the instruction side
    logic        fencei_in_wb;
    logic        fencei_ready;
    logic        fencei_flush_req;
    logic        fencei_flush_ack;
    // Instruction currently in writeback
    logic        wb_instr_valid;
    logic [31:0] wb_instr_word;
    // MPU error, bus error or trigger match on the writeback instruction
    logic        wb_prior_exc;
    // Privilege state
    priv_lvl_e   priv_lvl;
    logic        mstatus_tw;
    // Exception outcome of the writeback instruction
    logic        exception_in_wb;
    logic [7:0]  exception_cause;
    // Decoder view of the writeback instruction
    logic        wb_mret_insn;
    logic        wb_wfi_insn;
    logic        debug_wfi_no_sleep;
  } obs_t;

endpackage

`default_nettype wire
